// ==== rtl/dac_pkg.sv ====
//**************************************************************************
// dac playback package
// sample word and bit index types, serializer states, buffer defaults
//**************************************************************************

package dac_pkg;

    // one audio sample word, sent MSB first
    typedef logic [31:0] sample_t;

    // position of the bit on the wire within a word
    typedef logic [4:0] bit_idx_t;

    // serializer states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PRIME,
        ST_WAIT_FRAME,
        ST_SHIFT
    } i2s_state_t;

    //**********************************************************************
    // buffer defaults
    //**********************************************************************

    // 64 word sample buffer
    localparam int DEF_BUF_ADDR_W = 6;

    // words needed before playback may start
    localparam int DEF_PRIME_LEVEL = 48;

    // status thresholds
    localparam int DEF_ALMOST_FULL_LEVEL  = 60;
    localparam int DEF_ALMOST_EMPTY_LEVEL = 8;

endpackage

// ==== rtl/sample_ram.sv ====
//**************************************************************************
// sample RAM
// single port word memory, registered read data
//**************************************************************************
`timescale 1ns/1ps

module sample_ram #(
    parameter int BUF_ADDR_W = dac_pkg::DEF_BUF_ADDR_W
) (
    input  logic                  mclk,
    input  logic                  ram_en_i,
    input  logic                  ram_we_i,
    input  logic [BUF_ADDR_W-1:0] ram_addr_i,
    input  dac_pkg::sample_t      ram_wdata_i,
    output dac_pkg::sample_t      ram_rdata_o
);
    import dac_pkg::*;

    localparam int DEPTH = 2 ** BUF_ADDR_W;

    sample_t mem [0:DEPTH-1];

    always_ff @(posedge mclk) begin
        if (ram_en_i) begin
            if (ram_we_i) begin
                mem[ram_addr_i] <= ram_wdata_i;
            end else begin
                ram_rdata_o <= mem[ram_addr_i];
            end
        end
    end

endmodule

// ==== rtl/buffer_arbiter.sv ====
//**************************************************************************
// buffer arbiter
// round robin between host writes and serializer reads on one RAM port
//**************************************************************************
`timescale 1ns/1ps

module buffer_arbiter #(
    parameter int BUF_ADDR_W = dac_pkg::DEF_BUF_ADDR_W
) (
    input  logic                  mclk,
    input  logic                  reset_n,
    input  logic                  wr_req_i,
    input  logic [BUF_ADDR_W-1:0] wr_addr_i,
    input  dac_pkg::sample_t      wr_data_i,
    input  logic                  rd_req_i,
    input  logic [BUF_ADDR_W-1:0] rd_addr_i,
    output logic                  wr_grant_o,
    output logic                  rd_grant_o,
    output logic                  rd_valid_o,
    output logic                  ram_en_o,
    output logic                  ram_we_o,
    output logic [BUF_ADDR_W-1:0] ram_addr_o,
    output dac_pkg::sample_t      ram_wdata_o
);

    // read won the last contested or uncontested grant
    logic last_rd;

    // on a tie the side that lost last time goes first
    assign wr_grant_o = wr_req_i && (!rd_req_i || last_rd);
    assign rd_grant_o = rd_req_i && (!wr_req_i || !last_rd);

    assign ram_en_o    = wr_grant_o || rd_grant_o;
    assign ram_we_o    = wr_grant_o;
    assign ram_addr_o  = wr_grant_o ? wr_addr_i : rd_addr_i;
    assign ram_wdata_o = wr_data_i;

    always_ff @(posedge mclk or negedge reset_n) begin
        if (!reset_n) begin
            last_rd    <= 1'b0;
            rd_valid_o <= 1'b0;
        end else begin
            if (ram_en_o) begin
                last_rd <= rd_grant_o;
            end
            // registered RAM read data is ready one cycle after the grant
            rd_valid_o <= rd_grant_o;
        end
    end

    // a read that lost the tie goes through on the next cycle
    assert property (@(posedge mclk) disable iff (!reset_n)
        rd_req_i && !rd_grant_o |=> rd_req_i && rd_grant_o)
        else $error("read request not granted on the following cycle");

endmodule

// ==== rtl/host_write_port.sv ====
//**************************************************************************
// host write port
// stages host words, writes them to the sample RAM, tracks the fill
// level and hands a credit back for every word the serializer takes
//**************************************************************************
`timescale 1ns/1ps

module host_write_port #(
    parameter int BUF_ADDR_W         = dac_pkg::DEF_BUF_ADDR_W,
    parameter int ALMOST_FULL_LEVEL  = dac_pkg::DEF_ALMOST_FULL_LEVEL,
    parameter int ALMOST_EMPTY_LEVEL = dac_pkg::DEF_ALMOST_EMPTY_LEVEL
) (
    input  logic                  mclk,
    input  logic                  reset_n,
    input  logic                  wen_i,
    input  dac_pkg::sample_t      din_i,
    input  logic                  wr_grant_i,
    input  logic                  word_taken_i,
    output logic                  wr_req_o,
    output logic [BUF_ADDR_W-1:0] wr_addr_o,
    output dac_pkg::sample_t      wr_data_o,
    output logic [BUF_ADDR_W:0]   buf_level_o,
    output logic                  credit_o,
    output logic                  almost_full_o,
    output logic                  almost_empty_o
);
    import dac_pkg::*;

    localparam int DEPTH = 2 ** BUF_ADDR_W;
    localparam logic [BUF_ADDR_W:0] AF_LEVEL = (BUF_ADDR_W + 1)'(ALMOST_FULL_LEVEL);
    localparam logic [BUF_ADDR_W:0] AE_LEVEL = (BUF_ADDR_W + 1)'(ALMOST_EMPTY_LEVEL);

    // two entry staging queue
    sample_t    stage_mem [0:1];
    logic       stage_wr_ptr;
    logic       stage_rd_ptr;
    logic [1:0] stage_cnt;

    assign wr_req_o  = (stage_cnt != 2'd0);
    assign wr_data_o = stage_mem[stage_rd_ptr];

    always_ff @(posedge mclk) begin
        if (wen_i) begin
            stage_mem[stage_wr_ptr] <= din_i;
        end
    end

    always_ff @(posedge mclk or negedge reset_n) begin
        if (!reset_n) begin
            stage_wr_ptr   <= 1'b0;
            stage_rd_ptr   <= 1'b0;
            stage_cnt      <= 2'd0;
            wr_addr_o      <= '0;
            buf_level_o    <= '0;
            credit_o       <= 1'b0;
            almost_full_o  <= 1'b0;
            almost_empty_o <= 1'b1;
        end else begin
            if (wen_i) begin
                stage_wr_ptr <= ~stage_wr_ptr;
            end
            // a grant means the head word goes into RAM this cycle
            if (wr_grant_i) begin
                stage_rd_ptr <= ~stage_rd_ptr;
                wr_addr_o    <= wr_addr_o + 1'b1;
            end
            if (wen_i && !wr_grant_i) begin
                stage_cnt <= stage_cnt + 2'd1;
            end else if (!wen_i && wr_grant_i) begin
                stage_cnt <= stage_cnt - 2'd1;
            end
            // words in RAM not yet taken by the serializer
            if (wr_grant_i && !word_taken_i) begin
                buf_level_o <= buf_level_o + 1'b1;
            end else if (!wr_grant_i && word_taken_i) begin
                buf_level_o <= buf_level_o - 1'b1;
            end
            credit_o       <= word_taken_i;
            almost_full_o  <= (buf_level_o >= AF_LEVEL);
            almost_empty_o <= (buf_level_o < AE_LEVEL);
        end
    end

    // full staging queue must drain in the cycle of a new host word
    assert property (@(posedge mclk) disable iff (!reset_n)
        wen_i && stage_cnt == 2'd2 |-> wr_grant_i)
        else $error("staging queue overflow");

    // host wrote without a credit
    assert property (@(posedge mclk) disable iff (!reset_n)
        wen_i |-> (stage_cnt + buf_level_o) < DEPTH)
        else $error("buffer overflow, write with no credit");

endmodule

// ==== rtl/i2s_serializer.sv ====
//**************************************************************************
// I2S serializer
// frames on lrck, sends each word MSB first on bck rising edges,
// prefetches the next word and publishes left/right pairs
//**************************************************************************
`timescale 1ns/1ps

module i2s_serializer #(
    parameter int BUF_ADDR_W  = dac_pkg::DEF_BUF_ADDR_W,
    parameter int PRIME_LEVEL = dac_pkg::DEF_PRIME_LEVEL
) (
    input  logic                  mclk,
    input  logic                  reset_n,
    input  logic                  start_i,
    input  logic                  bck_i,
    input  logic                  lrck_i,
    input  logic [BUF_ADDR_W:0]   buf_level_i,
    input  logic                  rd_grant_i,
    input  logic                  rd_valid_i,
    input  dac_pkg::sample_t      rd_data_i,
    output logic                  rd_req_o,
    output logic [BUF_ADDR_W-1:0] rd_addr_o,
    output logic                  word_taken_o,
    output logic                  sdata_o,
    output logic                  playing_o,
    output dac_pkg::sample_t      pcm_left_o,
    output dac_pkg::sample_t      pcm_right_o
);
    import dac_pkg::*;

    localparam logic [BUF_ADDR_W:0] PRIME_LVL = (BUF_ADDR_W + 1)'(PRIME_LEVEL);
    localparam bit_idx_t PREFETCH_BIT = 5'd30;
    localparam bit_idx_t LAST_BIT     = 5'd31;

    i2s_state_t state_q;
    bit_idx_t   bit_idx_q;
    logic       bck_q;
    logic       lrck_q;
    logic       tx_bit_q;
    logic       right_q;

    // word on the wire, prefetched word, held left word
    sample_t shift_q;
    sample_t next_q;
    sample_t left_hold_q;

    logic shift_tick;
    logic word_end;
    logic prefetch_bit;
    logic frame_start;

    assign shift_tick   = (state_q == ST_SHIFT) && start_i && bck_i && !bck_q;
    assign word_end     = shift_tick && (bit_idx_q == LAST_BIT);
    assign prefetch_bit = shift_tick && (bit_idx_q == PREFETCH_BIT);
    assign frame_start  = (state_q == ST_WAIT_FRAME) && start_i && !lrck_i && lrck_q;

    // every read that lands consumes one buffer word
    assign word_taken_o = rd_valid_i;

    //**********************************************************************
    // word registers
    //**********************************************************************
    always_ff @(posedge mclk) begin
        if (rd_valid_i) begin
            next_q <= rd_data_i;
        end else if (prefetch_bit && buf_level_i == '0) begin
            // underrun, play silence
            next_q <= '0;
        end
        if (frame_start || word_end) begin
            shift_q <= next_q;
        end
        if (word_end && !right_q) begin
            left_hold_q <= shift_q;
        end
    end

    //**********************************************************************
    // framing FSM
    //**********************************************************************
    always_ff @(posedge mclk or negedge reset_n) begin
        if (!reset_n) begin
            state_q     <= ST_IDLE;
            bit_idx_q   <= '0;
            bck_q       <= 1'b0;
            lrck_q      <= 1'b0;
            tx_bit_q    <= 1'b0;
            right_q     <= 1'b0;
            sdata_o     <= 1'b0;
            playing_o   <= 1'b0;
            rd_req_o    <= 1'b0;
            rd_addr_o   <= '0;
            pcm_left_o  <= '0;
            pcm_right_o <= '0;
        end else begin
            bck_q   <= bck_i;
            lrck_q  <= lrck_i;
            // second register stage after the bck edge
            sdata_o <= (state_q == ST_SHIFT && start_i) ? tx_bit_q : 1'b0;

            // request stays up until the arbiter takes it
            if (rd_grant_i) begin
                rd_req_o  <= 1'b0;
                rd_addr_o <= rd_addr_o + 1'b1;
            end

            case (state_q)
                ST_IDLE: begin
                    if (start_i && buf_level_i >= PRIME_LVL && !rd_req_o && !rd_valid_i) begin
                        state_q  <= ST_PRIME;
                        rd_req_o <= 1'b1;
                    end
                end
                ST_PRIME: begin
                    if (rd_valid_i) begin
                        state_q   <= ST_WAIT_FRAME;
                        playing_o <= 1'b1;
                    end
                end
                ST_WAIT_FRAME: begin
                    // left word starts on lrck falling
                    if (frame_start) begin
                        state_q   <= ST_SHIFT;
                        bit_idx_q <= '0;
                        right_q   <= 1'b0;
                        tx_bit_q  <= 1'b0;
                    end
                end
                ST_SHIFT: begin
                    if (shift_tick) begin
                        tx_bit_q  <= shift_q[LAST_BIT - bit_idx_q];
                        bit_idx_q <= bit_idx_q + 1'b1;
                    end
                    if (prefetch_bit && buf_level_i != '0) begin
                        rd_req_o <= 1'b1;
                    end
                    if (word_end) begin
                        right_q <= ~right_q;
                        if (right_q) begin
                            pcm_left_o  <= left_hold_q;
                            pcm_right_o <= shift_q;
                        end
                    end
                end
                default: state_q <= ST_IDLE;
            endcase

            // stop from any active state
            if (!start_i && state_q != ST_IDLE) begin
                state_q   <= ST_IDLE;
                playing_o <= 1'b0;
            end
        end
    end

    // prefetch read has to finish before the next word is loaded
    assert property (@(posedge mclk) disable iff (!reset_n)
        word_end |-> !rd_req_o && !rd_valid_i)
        else $error("prefetch still pending at word boundary");

endmodule

// ==== rtl/dac_top.sv ====
//**************************************************************************
// dac playback top
// host writer and I2S reader share one sample RAM through an arbiter
//**************************************************************************
`timescale 1ns/1ps

module dac_top #(
    parameter int BUF_ADDR_W         = dac_pkg::DEF_BUF_ADDR_W,
    parameter int PRIME_LEVEL        = dac_pkg::DEF_PRIME_LEVEL,
    parameter int ALMOST_FULL_LEVEL  = dac_pkg::DEF_ALMOST_FULL_LEVEL,
    parameter int ALMOST_EMPTY_LEVEL = dac_pkg::DEF_ALMOST_EMPTY_LEVEL
) (
    input  logic             mclk,
    input  logic             reset_n,
    input  logic             start_i,
    input  logic             wen_i,
    input  dac_pkg::sample_t din_i,
    input  logic             bck_i,
    input  logic             lrck_i,
    output logic             credit_o,
    output logic             sdata_o,
    output logic             playing_o,
    output logic             almost_full_o,
    output logic             almost_empty_o,
    output dac_pkg::sample_t pcm_left_o,
    output dac_pkg::sample_t pcm_right_o
);
    import dac_pkg::*;

    // writer side
    logic                  wr_req;
    logic                  wr_grant;
    logic [BUF_ADDR_W-1:0] wr_addr;
    sample_t               wr_data;
    logic [BUF_ADDR_W:0]   buf_level;
    logic                  word_taken;

    // reader side
    logic                  rd_req;
    logic                  rd_grant;
    logic                  rd_valid;
    logic [BUF_ADDR_W-1:0] rd_addr;
    sample_t               rd_data;

    // shared RAM port
    logic                  ram_en;
    logic                  ram_we;
    logic [BUF_ADDR_W-1:0] ram_addr;
    sample_t               ram_wdata;

    host_write_port #(
        .BUF_ADDR_W         (BUF_ADDR_W),
        .ALMOST_FULL_LEVEL  (ALMOST_FULL_LEVEL),
        .ALMOST_EMPTY_LEVEL (ALMOST_EMPTY_LEVEL)
    ) u_host_write_port (
        .mclk           (mclk),
        .reset_n        (reset_n),
        .wen_i          (wen_i),
        .din_i          (din_i),
        .wr_grant_i     (wr_grant),
        .word_taken_i   (word_taken),
        .wr_req_o       (wr_req),
        .wr_addr_o      (wr_addr),
        .wr_data_o      (wr_data),
        .buf_level_o    (buf_level),
        .credit_o       (credit_o),
        .almost_full_o  (almost_full_o),
        .almost_empty_o (almost_empty_o)
    );

    buffer_arbiter #(
        .BUF_ADDR_W (BUF_ADDR_W)
    ) u_buffer_arbiter (
        .mclk        (mclk),
        .reset_n     (reset_n),
        .wr_req_i    (wr_req),
        .wr_addr_i   (wr_addr),
        .wr_data_i   (wr_data),
        .rd_req_i    (rd_req),
        .rd_addr_i   (rd_addr),
        .wr_grant_o  (wr_grant),
        .rd_grant_o  (rd_grant),
        .rd_valid_o  (rd_valid),
        .ram_en_o    (ram_en),
        .ram_we_o    (ram_we),
        .ram_addr_o  (ram_addr),
        .ram_wdata_o (ram_wdata)
    );

    sample_ram #(
        .BUF_ADDR_W (BUF_ADDR_W)
    ) u_sample_ram (
        .mclk        (mclk),
        .ram_en_i    (ram_en),
        .ram_we_i    (ram_we),
        .ram_addr_i  (ram_addr),
        .ram_wdata_i (ram_wdata),
        .ram_rdata_o (rd_data)
    );

    i2s_serializer #(
        .BUF_ADDR_W  (BUF_ADDR_W),
        .PRIME_LEVEL (PRIME_LEVEL)
    ) u_i2s_serializer (
        .mclk         (mclk),
        .reset_n      (reset_n),
        .start_i      (start_i),
        .bck_i        (bck_i),
        .lrck_i       (lrck_i),
        .buf_level_i  (buf_level),
        .rd_grant_i   (rd_grant),
        .rd_valid_i   (rd_valid),
        .rd_data_i    (rd_data),
        .rd_req_o     (rd_req),
        .rd_addr_o    (rd_addr),
        .word_taken_o (word_taken),
        .sdata_o      (sdata_o),
        .playing_o    (playing_o),
        .pcm_left_o   (pcm_left_o),
        .pcm_right_o  (pcm_right_o)
    );

endmodule

// ==== testbench/tb_dac_top.sv ====
//**************************************************************************
// dac playback testbench
// credit based host model, I2S clocks, serial capture and assertion checks
//**************************************************************************
`timescale 1ns/1ps

module tb_dac_top;
    import dac_pkg::*;

    localparam int DEPTH         = 2 ** DEF_BUF_ADDR_W;
    localparam int BCK_PERIOD_NS = 160;
    // first run, drain of a full buffer, silence and resume, with slack
    localparam int TOTAL_WORDS   = 48 + 64 + 8 + 8;
    localparam int WATCHDOG_NS   = TOTAL_WORDS * 64 * BCK_PERIOD_NS + 50000;

    logic    mclk;
    logic    reset_n;
    logic    start_i;
    logic    wen_i;
    sample_t din_i;
    logic    bck_i;
    logic    lrck_i;
    logic    credit_o;
    logic    sdata_o;
    logic    playing_o;
    logic    almost_full_o;
    logic    almost_empty_o;
    sample_t pcm_left_o;
    sample_t pcm_right_o;

    // host model
    integer     seed = 28340;
    int         credits;
    logic       write_en;
    sample_t    host_word;
    sample_t    ref_q [$];
    logic [8:0] ck_cnt;

    // serial capture
    logic    cap_active;
    logic    bck_prev;
    logic    lrck_prev;
    int      bit_cnt;
    logic    is_right;
    sample_t shreg;
    sample_t cap_word;
    sample_t exp_word;
    sample_t cap_left;
    sample_t cap_right;
    logic    word_done;
    logic    pair_done;

    int   errors;
    int   words_checked;
    int   zero_words;
    int   resume_mark;
    logic allow_zero;
    logic full_window;
    logic stop_window;

    dac_top DUT (.*);

    initial begin
        mclk = 1'b0;
        forever #10 mclk = ~mclk;
    end

    // bck every 4 mclk, lrck every 32 bck, both change on bck falling
    always @(posedge mclk) begin
        ck_cnt <= ck_cnt + 9'd1;
        bck_i  <= ck_cnt[2];
        lrck_i <= ck_cnt[8];
    end

    //**********************************************************************
    // host model
    //**********************************************************************
    always @(posedge mclk) begin
        if (!reset_n) begin
            credits = DEPTH;
            wen_i  <= 1'b0;
        end else begin
            if (credit_o) begin
                credits = credits + 1;
            end
            if (write_en && credits > 0) begin
                host_word = $random(seed);
                // zero is reserved for underrun silence
                if (host_word == '0) begin
                    host_word = 32'h1;
                end
                wen_i  <= 1'b1;
                din_i  <= host_word;
                ref_q.push_back(host_word);
                credits = credits - 1;
            end else begin
                wen_i <= 1'b0;
            end
        end
    end

    //**********************************************************************
    // serial capture on bck falling
    //**********************************************************************
    always @(negedge mclk) begin
        word_done = 1'b0;
        pair_done = 1'b0;
        if (!reset_n || !playing_o) begin
            cap_active = 1'b0;
        end else if (!cap_active && lrck_prev && !lrck_i) begin
            // MSB of the left word arrives one bck period later
            cap_active = 1'b1;
            bit_cnt    = 0;
            is_right   = 1'b0;
        end else if (cap_active && bck_prev && !bck_i) begin
            shreg   = {shreg[30:0], sdata_o};
            bit_cnt = bit_cnt + 1;
            if (bit_cnt == 32) begin
                bit_cnt  = 0;
                cap_word = shreg;
                if (shreg == '0 && allow_zero) begin
                    zero_words = zero_words + 1;
                end else if (ref_q.size() == 0) begin
                    errors = errors + 1;
                    $display("serial word 0x%08h arrived with no host word left", shreg);
                end else begin
                    exp_word      = ref_q.pop_front();
                    words_checked = words_checked + 1;
                    word_done     = 1'b1;
                    if (zero_words > 0) begin
                        allow_zero = 1'b0;
                    end
                end
                if (!is_right) begin
                    cap_left = shreg;
                end else begin
                    cap_right = shreg;
                    pair_done = 1'b1;
                end
                is_right = ~is_right;
            end
        end
        bck_prev  = bck_i;
        lrck_prev = lrck_i;
    end

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] expected);
        errors = errors + 1;
        $display("CHECK FAILED %s got 0x%0h expected 0x%0h at %0t", name, got, expected, $time);
    endtask

    //**********************************************************************
    // checks
    //**********************************************************************
    assert property (@(negedge mclk) !reset_n |-> {credit_o, playing_o, sdata_o} == 3'b000)
        else report_mismatch("credit_o/playing_o/sdata_o", {credit_o, playing_o, sdata_o}, 0);
    assert property (@(negedge mclk) !reset_n |-> almost_empty_o)
        else report_mismatch("almost_empty_o", almost_empty_o, 1);
    assert property (@(negedge mclk) !reset_n |-> pcm_left_o == '0 && pcm_right_o == '0)
        else report_mismatch("pcm_left_o/pcm_right_o", {pcm_left_o, pcm_right_o}, 0);

    assert property (@(negedge mclk) disable iff (!reset_n) credits >= 0 && credits <= DEPTH)
        else begin
            errors = errors + 1;
            $display("host credit balance left the range 0..%0d, now %0d", DEPTH, credits);
        end

    // full buffer, playback stopped
    assert property (@(negedge mclk) full_window |-> almost_full_o)
        else report_mismatch("almost_full_o", almost_full_o, 1);
    assert property (@(negedge mclk) full_window |-> !almost_empty_o)
        else report_mismatch("almost_empty_o", almost_empty_o, 0);
    assert property (@(negedge mclk) full_window |-> !credit_o)
        else report_mismatch("credit_o", credit_o, 0);

    // capture flags are set on the negedge before
    assert property (@(posedge mclk) word_done |-> cap_word == exp_word)
        else report_mismatch("sdata_o word", cap_word, exp_word);
    assert property (@(posedge mclk) pair_done |-> pcm_left_o == cap_left)
        else report_mismatch("pcm_left_o", pcm_left_o, cap_left);
    assert property (@(posedge mclk) pair_done |-> pcm_right_o == cap_right)
        else report_mismatch("pcm_right_o", pcm_right_o, cap_right);

    assert property (@(negedge mclk) stop_window |-> !playing_o)
        else report_mismatch("playing_o", playing_o, 0);
    assert property (@(negedge mclk) stop_window |-> !sdata_o)
        else report_mismatch("sdata_o", sdata_o, 0);

    //**********************************************************************
    // test sequence
    //**********************************************************************
    initial begin
        reset_n       = 1'b0;
        start_i       = 1'b0;
        wen_i         = 1'b0;
        din_i         = '0;
        bck_i         = 1'b0;
        lrck_i        = 1'b0;
        ck_cnt        = '0;
        credits       = DEPTH;
        write_en      = 1'b0;
        cap_active    = 1'b0;
        bck_prev      = 1'b0;
        lrck_prev     = 1'b0;
        bit_cnt       = 0;
        is_right      = 1'b0;
        shreg         = '0;
        cap_word      = '0;
        exp_word      = '0;
        cap_left      = '0;
        cap_right     = '0;
        word_done     = 1'b0;
        pair_done     = 1'b0;
        errors        = 0;
        words_checked = 0;
        zero_words    = 0;
        resume_mark   = 0;
        allow_zero    = 1'b0;
        full_window   = 1'b0;
        stop_window   = 1'b0;
        repeat (8) @(posedge mclk);
        reset_n <= 1'b1;

        // fill all 64 words with playback stopped
        write_en <= 1'b1;
        while (credits != 0) @(posedge mclk);
        while (!almost_full_o) @(posedge mclk);
        full_window = 1'b1;
        repeat (16) @(posedge mclk);
        full_window = 1'b0;

        // play with the host keeping the buffer topped up
        start_i <= 1'b1;
        while (!playing_o) @(posedge mclk);
        while (words_checked < 48) @(posedge mclk);

        // starve the buffer until silence goes out
        write_en  <= 1'b0;
        allow_zero = 1'b1;
        while (zero_words < 2) @(posedge mclk);

        resume_mark = words_checked;
        write_en   <= 1'b1;
        while (words_checked < resume_mark + 8) @(posedge mclk);

        start_i  <= 1'b0;
        write_en <= 1'b0;
        @(posedge mclk);
        stop_window = 1'b1;
        repeat (64) @(posedge mclk);
        stop_window = 1'b0;

        assert (zero_words > 0)
            else begin
                errors = errors + 1;
                $display("no underrun silence was shifted out");
            end
        $display("errors %0d, words checked %0d, zero words %0d",
                 errors, words_checked, zero_words);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the test sequence finished");
        $display("Test failed");
        $finish;
    end

endmodule

// ==== all.f ====
rtl/dac_pkg.sv
rtl/sample_ram.sv
rtl/buffer_arbiter.sv
rtl/host_write_port.sv
rtl/i2s_serializer.sv
rtl/dac_top.sv
testbench/tb_dac_top.sv

// ==== Makefile ====
# simulator, flags, top module and file list
VERILATOR = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       = tb_dac_top
FILELIST  = all.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
